// File: rvv_top.f
+incdir+logic
logic/rvv_pkg.sv
logic/rvv_multi_fifo.sv
logic/rvv_decode_unit.sv
logic/rvv_decode_ctrl.sv
logic/rvv_decode.sv
logic/rvv_top.sv
testbench/tb_rvv_top.sv

// File: Bender.yml
package:
  name: rvv_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvv_pkg.sv
      - logic/rvv_multi_fifo.sv
      - logic/rvv_decode_unit.sv
      - logic/rvv_decode_ctrl.sv
      - logic/rvv_decode.sv
      - logic/rvv_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/tb_rvv_top.sv

// File: testbench/tb_rvv_top.sv
// Testbench for the vector front end top level.
// Random instructions from an xorshift generator go into the command queue,
// a model expands each accepted one into its expected micro-ops, and every
// micro-op popped from the DUT is compared with the model in order.
// A consumer stall window forces inst_full to rise once during the run.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module tb_rvv_top
  import rvv_pkg::*;
;

  localparam int N_INST         = 300;
  localparam int STALL_AT       = 100;
  localparam int TIMEOUT_CYCLES = N_INST * 8 * 4 + 1000;

  logic       clk;
  logic       rst_n;
  logic       inst_push;
  INST_t      inst_data;
  logic       inst_full;
  logic       uop_pop;
  UOP_QUEUE_t uop_data;
  logic       uop_empty;

  logic [31:0] rng;
  int          issued;
  int          checked;
  int          cycle_cnt;
  logic        seen_full;
  logic        stalling;
  UOP_QUEUE_t  expected [$];

  rvv_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_push (inst_push),
    .inst_data (inst_data),
    .inst_full (inst_full),
    .uop_pop   (uop_pop),
    .uop_data  (uop_data),
    .uop_empty (uop_empty)
  );

  always #4 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d instructions issued, %0d micro-ops checked",
               cycle_cnt, issued, checked);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // biased towards the top registers so groups wrap past v31
  task automatic random_reg(output logic [4:0] r);
    rng = xorshift(rng);
    if (rng[7]) begin
      r = {2'b11, rng[2:0]};
    end else begin
      r = rng[4:0];
    end
  endtask

  task automatic random_inst(output INST_t inst);
    logic [1:0] form;
    rng = xorshift(rng);
    form        = 2'(rng[15:8] % 3);
    inst.opcode = OPCODE_e'(rng[2:0]);
    inst.lmul   = LMUL_e'(rng[4:3]);
    inst.src    = SRC_e'(form);
    random_reg(inst.vd);
    random_reg(inst.vs2);
    random_reg(inst.vs1);
    rng = xorshift(rng);
    inst.rs1_data = rng;
  endtask

  // reference expansion of one accepted instruction
  task automatic expand_inst(input INST_t inst);
    UOP_QUEUE_t u;
    int         group;
    group = 1 << inst.lmul;
    for (int i = 0; i < group; i++) begin
      u.opcode = inst.opcode;
      u.src    = inst.src;
      u.vd     = 5'(inst.vd + i);
      u.vs2    = 5'(inst.vs2 + i);
      u.vs1    = (inst.src == SRC_VV) ? 5'(inst.vs1 + i) : inst.vs1;
      if (inst.src == SRC_VX) begin
        u.rs1_data = inst.rs1_data;
      end else if (inst.src == SRC_VI) begin
        if (inst.opcode == OP_SLL || inst.opcode == OP_SRL) begin
          u.rs1_data = `XLEN'(unsigned'(inst.vs1));
        end else begin
          u.rs1_data = `XLEN'(signed'(inst.vs1));
        end
      end else begin
        u.rs1_data = '0;
      end
      u.uop_index = 3'(i);
      u.last_uop  = (i == group - 1);
      expected.push_back(u);
    end
  endtask

  task automatic compare_uop(input string name, input UOP_QUEUE_t exp, input UOP_QUEUE_t act);
    assert (act === exp) else begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "micro-op mismatch");
    end
  endtask

  // one falling edge worth of producer and consumer activity
  task automatic drive_cycle();
    INST_t inst;
    if (inst_full) begin
      seen_full = 1'b1;
    end
    stalling = (issued >= STALL_AT) && !seen_full;

    inst_push = 1'b0;
    if (issued < N_INST && !inst_full) begin
      rng = xorshift(rng);
      if (rng % 100 < 60) begin
        random_inst(inst);
        inst_data = inst;
        inst_push = 1'b1;
        expand_inst(inst);
        issued++;
      end
    end

    uop_pop = 1'b0;
    if (!uop_empty && !stalling) begin
      rng = xorshift(rng);
      if (rng % 100 < 50) begin
        assert (expected.size() > 0) else begin
          $display("micro-op queue not empty although no micro-op is expected");
          $display("TEST FAILED");
          $fatal(1, "unexpected micro-op");
        end
        compare_uop("uop_stream", expected.pop_front(), uop_data);
        checked++;
        uop_pop = 1'b1;
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    inst_push = 1'b0;
    inst_data = '0;
    uop_pop   = 1'b0;
    rng       = 32'h85198d5e;
    issued    = 0;
    checked   = 0;
    cycle_cnt = 0;
    seen_full = 1'b0;
    stalling  = 1'b0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    assert (uop_empty === 1'b1 && inst_full === 1'b0) else begin
      $display("after reset uop_empty is not high or inst_full is not low");
      $display("TEST FAILED");
      $fatal(1, "bad reset state");
    end

    while (!(issued == N_INST && expected.size() == 0)) begin
      drive_cycle();
      @(negedge clk);
    end
    inst_push = 1'b0;
    uop_pop   = 1'b0;
    @(negedge clk);

    assert (uop_empty === 1'b1) else begin
      $display("micro-op queue still holds entries after all expected ones were checked");
      $display("TEST FAILED");
      $fatal(1, "extra micro-ops");
    end
    assert (seen_full) else begin
      $display("inst_full never rose during the consumer stall");
      $display("TEST FAILED");
      $fatal(1, "no back-pressure seen");
    end

    $display("%0d instructions issued, %0d micro-ops checked", issued, checked);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/rvv_top.sv
// Vector front end top level. Instructions enter the command queue,
// the decode stage splits them into micro-ops, and the consumer drains
// the micro-op queue through uop_pop while uop_empty is low.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module rvv_top
  import rvv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       inst_push,
  input  INST_t      inst_data,
  output logic       inst_full,
  input  logic       uop_pop,
  output UOP_QUEUE_t uop_data,
  output logic       uop_empty
);

  INST_t      cq_head [`NUM_DE_INST];
  logic       cq_empty;
  logic       cq_1left_to_empty;
  logic       pop0_de2cq;
  logic       pop1_de2cq;
  logic       push0_de2uq;
  logic       push1_de2uq;
  logic       push2_de2uq;
  logic       push3_de2uq;
  UOP_QUEUE_t data0_de2uq;
  UOP_QUEUE_t data1_de2uq;
  UOP_QUEUE_t data2_de2uq;
  UOP_QUEUE_t data3_de2uq;
  logic       uq_full;
  logic       uq_1left_to_full;
  logic       uq_2left_to_full;
  logic       uq_3left_to_full;
  UOP_QUEUE_t uq_head [1];

  // command queue, one push and two heads for decode
  rvv_multi_fifo #(
    .payload_t (INST_t),
    .NUM_PUSH  (1),
    .NUM_POP   (`NUM_DE_INST),
    .DEPTH     (`CQ_DEPTH)
  ) u_command_queue (
    .clk                 (clk),
    .rst_n               (rst_n),
    .push                (inst_push),
    .push_data           ('{inst_data}),
    .pop                 ({pop1_de2cq, pop0_de2cq}),
    .pop_data            (cq_head),
    .full                (inst_full),
    .fifo_1left_to_full  (),
    .fifo_2left_to_full  (),
    .fifo_3left_to_full  (),
    .empty               (cq_empty),
    .fifo_1left_to_empty (cq_1left_to_empty)
  );

  rvv_decode u_decode (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .data0_cq2de               (cq_head[0]),
    .data1_cq2de               (cq_head[1]),
    .fifo_empty_cq2de          (cq_empty),
    .fifo_1left_to_empty_cq2de (cq_1left_to_empty),
    .pop0_de2cq                (pop0_de2cq),
    .pop1_de2cq                (pop1_de2cq),
    .push0_de2uq               (push0_de2uq),
    .data0_de2uq               (data0_de2uq),
    .push1_de2uq               (push1_de2uq),
    .data1_de2uq               (data1_de2uq),
    .push2_de2uq               (push2_de2uq),
    .data2_de2uq               (data2_de2uq),
    .push3_de2uq               (push3_de2uq),
    .data3_de2uq               (data3_de2uq),
    .fifo_full_uq2de           (uq_full),
    .fifo_1left_to_full_uq2de  (uq_1left_to_full),
    .fifo_2left_to_full_uq2de  (uq_2left_to_full),
    .fifo_3left_to_full_uq2de  (uq_3left_to_full)
  );

  // micro-op queue, four writes and one read per cycle
  rvv_multi_fifo #(
    .payload_t (UOP_QUEUE_t),
    .NUM_PUSH  (`NUM_DQ_UOP),
    .NUM_POP   (1),
    .DEPTH     (`UQ_DEPTH)
  ) u_uop_queue (
    .clk                 (clk),
    .rst_n               (rst_n),
    .push                ({push3_de2uq, push2_de2uq, push1_de2uq, push0_de2uq}),
    .push_data           ('{data0_de2uq, data1_de2uq, data2_de2uq, data3_de2uq}),
    .pop                 (uop_pop),
    .pop_data            (uq_head),
    .full                (uq_full),
    .fifo_1left_to_full  (uq_1left_to_full),
    .fifo_2left_to_full  (uq_2left_to_full),
    .fifo_3left_to_full  (uq_3left_to_full),
    .empty               (uop_empty),
    .fifo_1left_to_empty ()
  );

  assign uop_data = uq_head[0];

endmodule

`default_nettype wire

// File: logic/rvv_decode.sv
// Decode stage. Reads the two oldest command queue entries, expands both
// through a pair of decode units and lets the controller choose what is
// written to the micro-op queue each cycle.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module rvv_decode
  import rvv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  INST_t      data0_cq2de,
  input  INST_t      data1_cq2de,
  input  logic       fifo_empty_cq2de,
  input  logic       fifo_1left_to_empty_cq2de,
  output logic       pop0_de2cq,
  output logic       pop1_de2cq,
  output logic       push0_de2uq,
  output UOP_QUEUE_t data0_de2uq,
  output logic       push1_de2uq,
  output UOP_QUEUE_t data1_de2uq,
  output logic       push2_de2uq,
  output UOP_QUEUE_t data2_de2uq,
  output logic       push3_de2uq,
  output UOP_QUEUE_t data3_de2uq,
  input  logic       fifo_full_uq2de,
  input  logic       fifo_1left_to_full_uq2de,
  input  logic       fifo_2left_to_full_uq2de,
  input  logic       fifo_3left_to_full_uq2de
);

  logic                              pkg0_valid;
  logic                              pkg1_valid;
  logic [`NUM_DE_UOP-1:0]            unit0_uop_valid;
  UOP_QUEUE_t [`NUM_DE_UOP-1:0]      unit0_uop;
  logic [`NUM_DE_UOP-1:0]            unit1_uop_valid;
  UOP_QUEUE_t [`NUM_DE_UOP-1:0]      unit1_uop;
  logic [`UOP_INDEX_WIDTH-1:0]       uop_index_remain;

  // second entry exists only with at least two queued
  assign pkg0_valid = !fifo_empty_cq2de;
  assign pkg1_valid = !(fifo_empty_cq2de || fifo_1left_to_empty_cq2de);

  // head resumes where the controller stopped
  rvv_decode_unit u_decode_unit0 (
    .inst_valid      (pkg0_valid),
    .inst            (data0_cq2de),
    .uop_index_start (uop_index_remain),
    .uop_valid       (unit0_uop_valid),
    .uop             (unit0_uop)
  );

  rvv_decode_unit u_decode_unit1 (
    .inst_valid      (pkg1_valid),
    .inst            (data1_cq2de),
    .uop_index_start ('0),
    .uop_valid       (unit1_uop_valid),
    .uop             (unit1_uop)
  );

  rvv_decode_ctrl u_decode_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .pkg0_valid         (pkg0_valid),
    .pkg1_valid         (pkg1_valid),
    .unit0_uop_valid    (unit0_uop_valid),
    .unit0_uop          (unit0_uop),
    .unit1_uop_valid    (unit1_uop_valid),
    .unit1_uop          (unit1_uop),
    .fifo_full          (fifo_full_uq2de),
    .fifo_1left_to_full (fifo_1left_to_full_uq2de),
    .fifo_2left_to_full (fifo_2left_to_full_uq2de),
    .fifo_3left_to_full (fifo_3left_to_full_uq2de),
    .uop_index_remain   (uop_index_remain),
    .pop0               (pop0_de2cq),
    .pop1               (pop1_de2cq),
    .push0              (push0_de2uq),
    .push1              (push1_de2uq),
    .push2              (push2_de2uq),
    .push3              (push3_de2uq),
    .data0              (data0_de2uq),
    .data1              (data1_de2uq),
    .data2              (data2_de2uq),
    .data3              (data3_de2uq)
  );

endmodule

`default_nettype wire

// File: logic/rvv_decode_ctrl.sv
// Decode controller. Picks up to four decoded micro-ops per cycle, first
// from the head instruction, then from the second one once the head is
// done. Pops finished instructions from the command queue and remembers
// where a partly written head instruction has to resume.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module rvv_decode_ctrl
  import rvv_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           pkg0_valid,
  input  logic                           pkg1_valid,
  input  logic [`NUM_DE_UOP-1:0]         unit0_uop_valid,
  input  UOP_QUEUE_t [`NUM_DE_UOP-1:0]   unit0_uop,
  input  logic [`NUM_DE_UOP-1:0]         unit1_uop_valid,
  input  UOP_QUEUE_t [`NUM_DE_UOP-1:0]   unit1_uop,
  input  logic                           fifo_full,
  input  logic                           fifo_1left_to_full,
  input  logic                           fifo_2left_to_full,
  input  logic                           fifo_3left_to_full,
  output logic [`UOP_INDEX_WIDTH-1:0]    uop_index_remain,
  output logic                           pop0,
  output logic                           pop1,
  output logic                           push0,
  output logic                           push1,
  output logic                           push2,
  output logic                           push3,
  output UOP_QUEUE_t                     data0,
  output UOP_QUEUE_t                     data1,
  output UOP_QUEUE_t                     data2,
  output UOP_QUEUE_t                     data3
);

  localparam int IDX_W = `UOP_INDEX_WIDTH;
  localparam int CNT_W = IDX_W + 1;

  logic [CNT_W-1:0]             free_cnt;
  logic [CNT_W-1:0]             avail0;
  logic [CNT_W-1:0]             avail1;
  logic [CNT_W-1:0]             wr0;
  logic [CNT_W-1:0]             wr1;
  logic [`NUM_DQ_UOP-1:0]       push_vec;
  UOP_QUEUE_t                   data_vec [`NUM_DQ_UOP];
  logic [IDX_W-1:0]             remain_next;

  function automatic logic [CNT_W-1:0] count_valid(input logic [`NUM_DE_UOP-1:0] v);
    logic [CNT_W-1:0] n;
    n = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (v[k]) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // free slots in the micro-op queue
  always_comb begin
    if (fifo_full) begin
      free_cnt = CNT_W'(0);
    end else if (fifo_1left_to_full) begin
      free_cnt = CNT_W'(1);
    end else if (fifo_2left_to_full) begin
      free_cnt = CNT_W'(2);
    end else if (fifo_3left_to_full) begin
      free_cnt = CNT_W'(3);
    end else begin
      free_cnt = CNT_W'(`NUM_DQ_UOP);
    end
  end

  assign avail0 = count_valid(unit0_uop_valid);
  assign avail1 = count_valid(unit1_uop_valid);

  // head first, second instruction only fills what is left
  assign wr0 = (avail0 < free_cnt) ? avail0 : free_cnt;
  assign wr1 = (avail1 < free_cnt - wr0) ? avail1 : free_cnt - wr0;

  always_comb begin
    for (int p = 0; p < `NUM_DQ_UOP; p++) begin
      push_vec[p] = (CNT_W'(p) < wr0 + wr1);
      if (CNT_W'(p) < wr0) begin
        data_vec[p] = unit0_uop[p];
      end else begin
        data_vec[p] = unit1_uop[CNT_W'(p) - wr0];
      end
    end
  end

  assign push0 = push_vec[0];
  assign push1 = push_vec[1];
  assign push2 = push_vec[2];
  assign push3 = push_vec[3];
  assign data0 = data_vec[0];
  assign data1 = data_vec[1];
  assign data2 = data_vec[2];
  assign data3 = data_vec[3];

  // an instruction leaves the queue with its last micro-op
  assign pop0 = pkg0_valid && (wr0 == avail0);
  assign pop1 = pop0 && pkg1_valid && (wr1 == avail1);

  always_comb begin
    if (pkg0_valid && !pop0) begin
      remain_next = uop_index_remain + IDX_W'(wr0);
    end else if (pop0 && pkg1_valid && !pop1) begin
      remain_next = IDX_W'(wr1);
    end else begin
      remain_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else begin
      uop_index_remain <= remain_next;
    end
  end

  // a pop goes out together with the micro-op marked last by the unit
  a_pop0_on_last: assert property (@(posedge clk) disable iff (!rst_n)
    pop0 |-> unit0_uop[wr0 - 1'b1].last_uop);

  a_pop1_on_last: assert property (@(posedge clk) disable iff (!rst_n)
    pop1 |-> unit1_uop[wr1 - 1'b1].last_uop);

  // resume point always lies inside the head's register group
  a_remain_in_group: assert property (@(posedge clk) disable iff (!rst_n)
    pkg0_valid |-> unit0_uop_valid[0]);

endmodule

`default_nettype wire

// File: logic/rvv_decode_unit.sv
// Expands one vector instruction into its micro-ops, one per register of
// the group. Purely combinational; slot k carries micro-op number
// uop_index_start+k and is valid while that number is inside the group.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module rvv_decode_unit
  import rvv_pkg::*;
(
  input  logic                                inst_valid,
  input  INST_t                               inst,
  input  logic [`UOP_INDEX_WIDTH-1:0]         uop_index_start,
  output logic [`NUM_DE_UOP-1:0]              uop_valid,
  output UOP_QUEUE_t [`NUM_DE_UOP-1:0]        uop
);

  localparam int IDX_W = `UOP_INDEX_WIDTH;
  localparam int CNT_W = IDX_W + 1;

  logic [CNT_W-1:0] group_size;
  logic [`XLEN-1:0] scalar;

  assign group_size = CNT_W'(1) << inst.lmul;

  // scalar operand, shifts take the immediate unsigned
  always_comb begin
    case (inst.src)
      SRC_VX: begin
        scalar = inst.rs1_data;
      end
      SRC_VI: begin
        if (inst.opcode == OP_SLL || inst.opcode == OP_SRL) begin
          scalar = {{(`XLEN-5){1'b0}}, inst.vs1};
        end else begin
          scalar = {{(`XLEN-5){inst.vs1[4]}}, inst.vs1};
        end
      end
      default: begin
        scalar = '0;
      end
    endcase
  end

  for (genvar k = 0; k < `NUM_DE_UOP; k++) begin : g_slot
    logic [CNT_W-1:0] num;
    logic [4:0]       offset;

    assign num    = CNT_W'(uop_index_start) + CNT_W'(k);
    assign offset = 5'(num);

    assign uop_valid[k] = inst_valid && (num < group_size);

    // register numbers wrap at 32
    always_comb begin
      uop[k].opcode    = inst.opcode;
      uop[k].src       = inst.src;
      uop[k].vd        = inst.vd + offset;
      uop[k].vs2       = inst.vs2 + offset;
      if (inst.src == SRC_VV) begin
        uop[k].vs1 = inst.vs1 + offset;
      end else begin
        uop[k].vs1 = inst.vs1;
      end
      uop[k].rs1_data  = scalar;
      uop[k].uop_index = num[IDX_W-1:0];
      uop[k].last_uop  = (num == group_size - 1'b1);
    end
  end

endmodule

`default_nettype wire

// File: logic/rvv_multi_fifo.sv
// Circular queue with several push and pop ports per cycle.
// Active push and pop ports must be contiguous from port 0. Head entries
// appear on pop_data straight from storage, and the flags come from the
// registered count, so nothing written this cycle is visible before the edge.
// DEPTH must be a power of two.

`default_nettype none
`timescale 1ns/100ps

`include "rvv_defs.svh"

module rvv_multi_fifo
  import rvv_pkg::*;
#(
  parameter type payload_t = INST_t,
  parameter int  NUM_PUSH  = 1,
  parameter int  NUM_POP   = 1,
  parameter int  DEPTH     = `CQ_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_PUSH-1:0] push,
  input  payload_t            push_data [NUM_PUSH],
  input  logic [NUM_POP-1:0]  pop,
  output payload_t            pop_data [NUM_POP],
  output logic                full,
  output logic                fifo_1left_to_full,
  output logic                fifo_2left_to_full,
  output logic                fifo_3left_to_full,
  output logic                empty,
  output logic                fifo_1left_to_empty
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);

  payload_t          mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  push_cnt;
  logic [CNT_W-1:0]  pop_cnt;

  // number of active ports this cycle
  always_comb begin
    push_cnt = '0;
    pop_cnt  = '0;
    for (int k = 0; k < NUM_PUSH; k++) begin
      if (push[k]) begin
        push_cnt = push_cnt + 1'b1;
      end
    end
    for (int j = 0; j < NUM_POP; j++) begin
      if (pop[j]) begin
        pop_cnt = pop_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + ADDR_W'(push_cnt);
      rd_ptr <= rd_ptr + ADDR_W'(pop_cnt);
      count  <= count + push_cnt - pop_cnt;
    end
  end

  // port k lands k slots past the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_PUSH; k++) begin
      if (push[k]) begin
        mem[wr_ptr + ADDR_W'(k)] <= push_data[k];
      end
    end
  end

  for (genvar j = 0; j < NUM_POP; j++) begin : g_head
    assign pop_data[j] = mem[rd_ptr + ADDR_W'(j)];
  end

  assign full                = (count == CNT_W'(DEPTH));
  assign fifo_1left_to_full  = (count == CNT_W'(DEPTH - 1));
  assign fifo_2left_to_full  = (count == CNT_W'(DEPTH - 2));
  assign fifo_3left_to_full  = (count == CNT_W'(DEPTH - 3));
  assign empty               = (count == '0);
  assign fifo_1left_to_empty = (count == CNT_W'(1));

  // producers and consumers must honour the port order and the flags
  a_push_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
    (push & (push + 1'b1)) == '0);

  a_pop_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
    (pop & (pop + 1'b1)) == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_cnt <= CNT_W'(DEPTH) - count);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_cnt <= count);

endmodule

`default_nettype wire

// File: logic/rvv_pkg.sv
// Instruction and micro-op types for the vector front end.
// Modules take these through a wildcard import in their header.

`default_nettype none

`include "rvv_defs.svh"

package rvv_pkg;

  // reduced integer operation set
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_RSUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL
  } OPCODE_e;

  // operand form
  typedef enum logic [1:0] {
    SRC_VV,
    SRC_VX,
    SRC_VI
  } SRC_e;

  // register group size 1, 2, 4, 8
  typedef enum logic [1:0] {
    LMUL1,
    LMUL2,
    LMUL4,
    LMUL8
  } LMUL_e;

  // command queue entry, vs1 carries the immediate for VI
  typedef struct packed {
    OPCODE_e           opcode;
    SRC_e              src;
    LMUL_e             lmul;
    logic [4:0]        vd;
    logic [4:0]        vs2;
    logic [4:0]        vs1;
    logic [`XLEN-1:0]  rs1_data;
  } INST_t;

  // micro-op queue entry, rs1_data is the final scalar operand
  typedef struct packed {
    OPCODE_e                     opcode;
    SRC_e                        src;
    logic [4:0]                  vd;
    logic [4:0]                  vs2;
    logic [4:0]                  vs1;
    logic [`XLEN-1:0]            rs1_data;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic                        last_uop;
  } UOP_QUEUE_t;

endpackage

`default_nettype wire

// File: logic/rvv_defs.svh
// Sizing macros shared by the vector front end.
// Included by the package and by every RTL module; the guard keeps
// repeated inclusion harmless.

`ifndef RVV_DEFS_SVH
`define RVV_DEFS_SVH

// scalar operand width
`define XLEN            32

// decode throughput
`define NUM_DE_INST     2
`define NUM_DE_UOP      8
`define NUM_DQ_UOP      4
`define UOP_INDEX_WIDTH 3

// queue depths, powers of two
`define CQ_DEPTH        8
`define UQ_DEPTH        16

`endif
